// ==== list.f ====
source/wide_port_pkg.sv
source/beat_serializer.sv
source/read_assembler.sv
source/port_bridge.sv
source/narrow_ram_bridge.sv
verif/narrow_ram_model.sv
verif/tb_narrow_ram_bridge.sv

// ==== source/beat_serializer.sv ====
`timescale 1ns/1ps

module beat_serializer (
  input  logic                      f_clk,
  input  logic                      arst_n,
  input  wide_port_pkg::wide_addr_t wide_addr,
  input  wide_port_pkg::wide_data_t wide_d,
  input  wide_port_pkg::lane_en_t   wide_ce,
  input  logic                      wide_we,
  output wide_port_pkg::addr_t      ram_addr,
  output wide_port_pkg::data_t      ram_d,
  output logic                      ram_ce,
  output logic                      ram_we
);
  import wide_port_pkg::*;

  beat_e beat;
  logic  lane;
  logic  req;

  assign req = |wide_ce;

  always_ff @(posedge f_clk or negedge arst_n) begin
    if (!arst_n) begin
      beat <= beat_lo;
    end else begin
      beat <= next_beat(beat, req);
    end
  end

  assign lane = (beat == beat_hi); // lane index follows the beat.

  // zero latency from the wide inputs to the narrow port
  always_comb begin
    ram_addr = wide_addr[ADDR_W*lane +: ADDR_W];
    ram_d    = wide_d[DATA_W*lane +: DATA_W];
    ram_ce   = wide_ce[lane]; // low whenever the wide side idles.
    ram_we   = wide_we;
  end

  a_beat_hi_single : assert property (
    @(posedge f_clk) disable iff (!arst_n)
      (beat == beat_hi) |=> (beat == beat_lo)
  ) else $error("beat_serializer: beat_hi held for two cycles.");

endmodule

// ==== source/narrow_ram_bridge.sv ====
`timescale 1ns/1ps

module narrow_ram_bridge (
  input  logic                      f_clk,
  input  logic                      arst_n,

  // wide requester side
  input  wide_port_pkg::wide_addr_t wide_addr [wide_port_pkg::NUM_PORTS],
  input  wide_port_pkg::wide_data_t wide_d    [wide_port_pkg::NUM_PORTS],
  input  wide_port_pkg::lane_en_t   wide_ce   [wide_port_pkg::NUM_PORTS],
  input  logic                      wide_we   [wide_port_pkg::NUM_PORTS],
  output wide_port_pkg::wide_data_t wide_q    [wide_port_pkg::NUM_PORTS],

  // narrow RAM side
  output wide_port_pkg::addr_t      ram_addr  [wide_port_pkg::NUM_PORTS],
  output wide_port_pkg::data_t      ram_d     [wide_port_pkg::NUM_PORTS],
  output logic                      ram_ce    [wide_port_pkg::NUM_PORTS],
  output logic                      ram_we    [wide_port_pkg::NUM_PORTS],
  input  wide_port_pkg::data_t      ram_q     [wide_port_pkg::NUM_PORTS]
);
  import wide_port_pkg::*;

  // ports are fully independent of each other.
  generate
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      port_bridge port_bridge_i (
        .f_clk    (f_clk),
        .arst_n   (arst_n),
        .wide_addr(wide_addr[p]),
        .wide_d   (wide_d[p]),
        .wide_ce  (wide_ce[p]),
        .wide_we  (wide_we[p]),
        .wide_q   (wide_q[p]),
        .ram_addr (ram_addr[p]),
        .ram_d    (ram_d[p]),
        .ram_ce   (ram_ce[p]),
        .ram_we   (ram_we[p]),
        .ram_q    (ram_q[p])
      );
    end
  endgenerate

endmodule

// ==== source/port_bridge.sv ====
`timescale 1ns/1ps

module port_bridge (
  input  logic                      f_clk,
  input  logic                      arst_n,
  input  wide_port_pkg::wide_addr_t wide_addr,
  input  wide_port_pkg::wide_data_t wide_d,
  input  wide_port_pkg::lane_en_t   wide_ce,
  input  logic                      wide_we,
  output wide_port_pkg::wide_data_t wide_q,
  output wide_port_pkg::addr_t      ram_addr,
  output wide_port_pkg::data_t      ram_d,
  output logic                      ram_ce,
  output logic                      ram_we,
  input  wide_port_pkg::data_t      ram_q
);
  import wide_port_pkg::*;

  // outgoing side sends one lane per beat
  beat_serializer beat_serializer_i (
    .f_clk    (f_clk),
    .arst_n   (arst_n),
    .wide_addr(wide_addr),
    .wide_d   (wide_d),
    .wide_ce  (wide_ce),
    .wide_we  (wide_we),
    .ram_addr (ram_addr),
    .ram_d    (ram_d),
    .ram_ce   (ram_ce),
    .ram_we   (ram_we)
  );

  // returning side pairs two narrow words.
  read_assembler read_assembler_i (
    .f_clk (f_clk),
    .arst_n(arst_n),
    .wide_ce(wide_ce),
    .ram_q (ram_q),
    .wide_q(wide_q)
  );

  // a request seen on its first beat must still be there on the second.
  a_request_held : assert property (
    @(posedge f_clk) disable iff (!arst_n)
      (|wide_ce && beat_serializer_i.beat == beat_lo) |=>
        $stable(wide_addr) && $stable(wide_d) && $stable(wide_ce) && $stable(wide_we)
  ) else $error("port_bridge: wide request changed before its second beat.");

endmodule

// ==== source/read_assembler.sv ====
`timescale 1ns/1ps

module read_assembler (
  input  logic                      f_clk,
  input  logic                      arst_n,
  input  wide_port_pkg::lane_en_t   wide_ce,
  input  wide_port_pkg::data_t      ram_q,
  output wide_port_pkg::wide_data_t wide_q
);
  import wide_port_pkg::*;

  lane_en_t ce_pipe [READ_LATENCY];
  lane_en_t ce_dly;
  beat_e    beat;
  data_t    q_hold;
  logic     load;

  // enables travel alongside the RAM read pipeline.
  always_ff @(posedge f_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < READ_LATENCY; i++) begin
        ce_pipe[i] <= '0;
      end
    end else begin
      ce_pipe[0] <= wide_ce;
      for (int i = 1; i < READ_LATENCY; i++) begin
        ce_pipe[i] <= ce_pipe[i-1];
      end
    end
  end

  assign ce_dly = ce_pipe[READ_LATENCY-1]; // lines up with data on ram_q.

  always_ff @(posedge f_clk or negedge arst_n) begin
    if (!arst_n) begin
      beat <= beat_lo;
    end else begin
      beat <= next_beat(beat, |ce_dly);
    end
  end

  assign load = (beat == beat_hi);

  // holds the lane 0 word for one cycle until its partner arrives.
  always_ff @(posedge f_clk) begin
    q_hold <= ram_q;
  end

  always_ff @(posedge f_clk or negedge arst_n) begin
    if (!arst_n) begin
      wide_q <= '0;
    end else if (load) begin
      wide_q <= {ram_q, q_hold}; // low lane in the low half.
    end
  end

  // with back-to-back requests the delayed enable stays high, but the
  // tracker still has to pass through beat_lo between two loads.
  a_load_spacing : assert property (
    @(posedge f_clk) disable iff (!arst_n)
      (|ce_dly) [*3] |-> (beat == beat_lo) || $past(beat == beat_lo)
  ) else $error("read_assembler: no beat_lo within three delayed enables.");

endmodule

// ==== source/wide_port_pkg.sv ====
package wide_port_pkg;

  localparam int NUM_PORTS    = 4;
  localparam int NUM_LANES    = 2;
  localparam int ADDR_W       = 12;
  localparam int DATA_W       = 64;
  localparam int READ_LATENCY = 7; // narrow read beat to data on ram_q.

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [DATA_W-1:0]           data_t;
  typedef logic [NUM_LANES*ADDR_W-1:0] wide_addr_t; // lane 0 in the low bits.
  typedef logic [NUM_LANES*DATA_W-1:0] wide_data_t;
  typedef logic [NUM_LANES-1:0]        lane_en_t;

  // lane currently on the narrow port
  typedef enum logic {
    beat_lo = 1'b0,
    beat_hi = 1'b1
  } beat_e;

  // shared by the request side and the delayed read side, so both
  // trackers stay in step with each other.
  function automatic beat_e next_beat(beat_e beat, logic req);
    beat_e nxt;
    if (beat == beat_hi) begin
      nxt = beat_lo; // a request is never longer than two beats.
    end else if (req) begin
      nxt = beat_hi;
    end else begin
      nxt = beat_lo;
    end
    return nxt;
  endfunction

endpackage

// ==== verif/narrow_ram_model.sv ====
`timescale 1ns/1ps

module narrow_ram_model #(
  parameter int PORT_ID = 0
) (
  input  logic                 f_clk,
  input  wide_port_pkg::addr_t ram_addr,
  input  wide_port_pkg::data_t ram_d,
  input  logic                 ram_ce,
  input  logic                 ram_we,
  output wide_port_pkg::data_t ram_q
);
  import wide_port_pkg::*;

  data_t mem [2**ADDR_W];
  data_t rd_pipe [READ_LATENCY];

  // power-up contents differ per port and per address.
  initial begin
    logic [31:0] mix;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mix = a * 32'h9e3779b1;
      mem[a] = {mix, 20'(PORT_ID), addr_t'(a)};
    end
    for (int i = 0; i < READ_LATENCY; i++) begin
      rd_pipe[i] = '0;
    end
  end

  always @(posedge f_clk) begin
    if (ram_ce && ram_we) begin
      mem[ram_addr] <= ram_d; // write lands at the end of the beat.
    end
    if (ram_ce && !ram_we) begin
      rd_pipe[0] <= mem[ram_addr];
    end else begin
      rd_pipe[0] <= '0; // nothing read in this beat.
    end
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign ram_q = rd_pipe[READ_LATENCY-1];

endmodule

// ==== verif/tb_narrow_ram_bridge.sv ====
`timescale 1ns/1ps

module tb_narrow_ram_bridge;
  import wide_port_pkg::*;

  localparam int N_DIRECT        = 6;
  localparam int N_B2B           = 10;
  localparam int N_SINGLE        = 8;
  localparam int N_RANDOM        = 40;
  localparam int TOTAL_REQS      = 2*N_DIRECT + N_B2B + N_SINGLE + NUM_PORTS*N_RANDOM;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS*4 + 100;
  localparam int STIM_DEPTH      = 64;
  localparam int LOAD_SLOTS      = 16;
  localparam int Q_DELAY         = 9; // first request cycle to new wide_q.

  typedef struct packed {
    wide_addr_t addr;
    wide_data_t d;
    lane_en_t   ce;
    logic       we;
  } req_t;

  logic       f_clk;
  logic       arst_n;
  wide_addr_t wide_addr [NUM_PORTS];
  wide_data_t wide_d    [NUM_PORTS];
  lane_en_t   wide_ce   [NUM_PORTS];
  logic       wide_we   [NUM_PORTS];
  wide_data_t wide_q    [NUM_PORTS];
  addr_t      ram_addr  [NUM_PORTS];
  data_t      ram_d     [NUM_PORTS];
  logic       ram_ce    [NUM_PORTS];
  logic       ram_we    [NUM_PORTS];
  data_t      ram_q     [NUM_PORTS];

  logic [31:0] rng_state;
  int          cycle;
  int          err_cnt;

  req_t       stim_buf [NUM_PORTS][STIM_DEPTH];
  int         stim_wr  [NUM_PORTS];
  int         stim_rd  [NUM_PORTS];
  req_t       cur      [NUM_PORTS]; // request currently on the wide inputs.
  int         beat_idx [NUM_PORTS];
  data_t      ref_mem  [NUM_PORTS][2**ADDR_W];
  logic       load_due [NUM_PORTS][LOAD_SLOTS];
  wide_data_t load_val [NUM_PORTS][LOAD_SLOTS];
  wide_data_t exp_q    [NUM_PORTS];

  narrow_ram_bridge narrow_ram_bridge_i (
    .f_clk    (f_clk),
    .arst_n   (arst_n),
    .wide_addr(wide_addr),
    .wide_d   (wide_d),
    .wide_ce  (wide_ce),
    .wide_we  (wide_we),
    .wide_q   (wide_q),
    .ram_addr (ram_addr),
    .ram_d    (ram_d),
    .ram_ce   (ram_ce),
    .ram_we   (ram_we),
    .ram_q    (ram_q)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ram
    narrow_ram_model #(.PORT_ID(p)) narrow_ram_model_i (
      .f_clk   (f_clk),
      .ram_addr(ram_addr[p]),
      .ram_d   (ram_d[p]),
      .ram_ce  (ram_ce[p]),
      .ram_we  (ram_we[p]),
      .ram_q   (ram_q[p])
    );
  end

  initial begin
    f_clk = 1'b0;
    forever #50 f_clk = ~f_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge f_clk);
    fail_stop($sformatf("watchdog: run timed out after %0d cycles.", WATCHDOG_CYCLES));
  end

  task automatic fail_stop(string why);
    err_cnt++;
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error.");
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_wide(string name, wide_data_t got, wide_data_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t rand_addr(addr_t mask);
    logic [31:0] r;
    r = next_rand();
    return r[ADDR_W-1:0] & mask;
  endfunction

  function automatic data_t rand_data();
    return {next_rand(), next_rand()};
  endfunction

  // same contents as the narrow RAM model after power-up.
  function automatic data_t fill_word(int p, int a);
    logic [31:0] mix;
    mix = a * 32'h9e3779b1;
    return {mix, 20'(p), addr_t'(a)};
  endfunction

  task automatic push_req(int p, wide_addr_t a, wide_data_t d, lane_en_t ce, logic we);
    req_t r;
    if (stim_wr[p] >= STIM_DEPTH) begin
      fail_stop("stimulus buffer overflow in the testbench.");
    end
    r.addr = a;
    r.d    = d;
    r.ce   = ce;
    r.we   = we;
    stim_buf[p][stim_wr[p]] = r;
    stim_wr[p]++;
  endtask

  // a new request updates the expected wide_q and the reference memory.
  task automatic predict(int p);
    addr_t a;
    data_t half [NUM_LANES];
    int    slot;
    for (int l = 0; l < NUM_LANES; l++) begin
      a       = cur[p].addr[ADDR_W*l +: ADDR_W];
      half[l] = '0;
      if (cur[p].ce[l] && cur[p].we) begin
        ref_mem[p][a] = cur[p].d[DATA_W*l +: DATA_W];
      end else if (cur[p].ce[l]) begin
        half[l] = ref_mem[p][a];
      end
    end
    slot = (cycle + Q_DELAY) % LOAD_SLOTS;
    load_due[p][slot] = 1'b1;
    load_val[p][slot] = {half[1], half[0]};
  endtask

  task automatic check_outputs();
    int    lane;
    int    slot;
    string sfx;
    slot = cycle % LOAD_SLOTS;
    for (int p = 0; p < NUM_PORTS; p++) begin
      lane = beat_idx[p];
      sfx  = $sformatf("[%0d]", p);
      check_bit({"ram_ce", sfx}, ram_ce[p], cur[p].ce[lane]);
      check_bit({"ram_we", sfx}, ram_we[p], cur[p].we);
      if (cur[p].ce != '0) begin
        check_addr({"ram_addr", sfx}, ram_addr[p], cur[p].addr[ADDR_W*lane +: ADDR_W]);
        check_data({"ram_d", sfx}, ram_d[p], cur[p].d[DATA_W*lane +: DATA_W]);
      end
      if (load_due[p][slot]) begin
        exp_q[p]          = load_val[p][slot];
        load_due[p][slot] = 1'b0;
      end
      check_wide({"wide_q", sfx}, wide_q[p], exp_q[p]);
    end
  endtask

  // drives on the rising edge and checks on the falling edge of one f_clk cycle.
  task automatic step_cycle();
    @(posedge f_clk);
    cycle++;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (beat_idx[p] == 0 && cur[p].ce != '0) begin
        beat_idx[p] = 1; // inputs held for the second beat.
      end else begin
        beat_idx[p] = 0;
        if (stim_rd[p] < stim_wr[p]) begin
          cur[p] = stim_buf[p][stim_rd[p]];
          stim_rd[p]++;
        end else begin
          cur[p] = '0;
        end
        if (cur[p].ce != '0) begin
          predict(p);
        end
        wide_addr[p] <= cur[p].addr;
        wide_d[p]    <= cur[p].d;
        wide_ce[p]   <= cur[p].ce;
        wide_we[p]   <= cur[p].we;
      end
    end
    @(negedge f_clk);
    check_outputs();
  endtask

  function automatic logic busy();
    logic b;
    b = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (stim_rd[p] < stim_wr[p] || (beat_idx[p] == 0 && cur[p].ce != '0)) begin
        b = 1'b1;
      end
    end
    return b;
  endfunction

  // run queued requests, then let the last reads come back.
  task automatic drain();
    while (busy()) begin
      step_cycle();
    end
    repeat (Q_DELAY + 3) step_cycle();
    for (int p = 0; p < NUM_PORTS; p++) begin
      stim_wr[p] = 0;
      stim_rd[p] = 0;
    end
  endtask

  initial begin
    wide_addr_t  pairs [N_DIRECT];
    logic [31:0] r;
    lane_en_t    ce;
    rng_state = 32'h693f0a7c;
    cycle     = 0;
    err_cnt   = 0;
    arst_n    = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      wide_addr[p] = '0;
      wide_d[p]    = '0;
      wide_ce[p]   = '0;
      wide_we[p]   = 1'b0;
      stim_wr[p]   = 0;
      stim_rd[p]   = 0;
      cur[p]       = '0;
      beat_idx[p]  = 0;
      exp_q[p]     = '0;
      for (int s = 0; s < LOAD_SLOTS; s++) begin
        load_due[p][s] = 1'b0;
        load_val[p][s] = '0;
      end
      for (int a = 0; a < 2**ADDR_W; a++) begin
        ref_mem[p][a] = fill_word(p, a);
      end
    end
    repeat (3) @(posedge f_clk);
    arst_n <= 1'b1;

    $display("idle after reset");
    repeat (4) step_cycle();

    $display("write then read back on port 0");
    for (int i = 0; i < N_DIRECT; i++) begin
      pairs[i] = {rand_addr(12'hfff), rand_addr(12'hfff)};
      push_req(0, pairs[i], {rand_data(), rand_data()}, 2'b11, 1'b1);
    end
    for (int i = 0; i < N_DIRECT; i++) begin
      push_req(0, pairs[i], {rand_data(), rand_data()}, 2'b11, 1'b0);
    end
    drain();

    $display("back-to-back reads on port 1");
    for (int i = 0; i < N_B2B; i++) begin
      push_req(1, {rand_addr(12'hfff), rand_addr(12'hfff)}, '0, 2'b11, 1'b0);
    end
    drain();

    $display("single-lane requests on port 2");
    for (int i = 0; i < N_SINGLE; i++) begin
      ce = (i % 2 == 0) ? 2'b01 : 2'b10;
      push_req(2, {rand_addr(12'h00f), rand_addr(12'h00f)}, {rand_data(), rand_data()},
               ce, i < N_SINGLE/2);
    end
    drain();

    $display("mixed traffic on all ports");
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < N_RANDOM; i++) begin
        r = next_rand();
        if (r[1:0] == 2'b00) begin
          push_req(p, '0, '0, 2'b00, 1'b0); // one idle cycle.
        end else begin
          ce = (r[3:2] == 2'b00) ? 2'b11 : lane_en_t'(r[3:2]);
          push_req(p, {rand_addr(12'h03f), rand_addr(12'h03f)}, {rand_data(), rand_data()},
                   ce, r[4]);
        end
      end
    end
    drain();

    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_stop("errors were recorded during the run.");
    end
  end

endmodule
